// ==== serial_tag.f ====
src/tag_cfg_pkg.sv
src/tag_link_pkg.sv
src/tag_reset_detect.sv
src/tag_master.sv
src/tag_client.sv
src/serial_tag_top.sv
testbench/tb_serial_tag.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the serial tag testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert \
   --top-module tb_serial_tag \
   -f serial_tag.f \
   -o Vtb_serial_tag

./obj_dir/Vtb_serial_tag | tee "$LOG"

if grep -q "Simulation PASSED" "$LOG"; then
   echo "run_sim: pass"
   exit 0
else
   echo "run_sim: fail"
   exit 1
fi

// ==== testbench/serial_tag_stim.txt ====
// kind id flag len payload  cnt0 cnt1 cnt2 cnt3  data0 data1 data2 data3
// kind 0 packet, 1 raw bits, 2 zeros, 3 packet after random gap, ff end
// data write to clients 1 and 2
0 1 1 8 a5    0 1 0 0   00 a5 00 00
0 2 1 8 3c    0 0 1 0   00 a5 3c 00
// two words to client 0, upper word stays
0 0 1 10 5ac3 2 0 0 0   5a a5 3c 00
// client reset, partial word, reset, full word, lone reset
0 3 0 4 f     0 0 0 0   5a a5 3c 00
0 3 1 3 5     0 0 0 0   5a a5 3c 00
0 3 0 1 1     0 0 0 0   5a a5 3c 00
0 3 1 8 96    0 0 0 1   5a a5 3c 96
0 3 0 2 3     0 0 0 0   5a a5 3c 96
// null packets, then a normal one
0 1 1 0 0     0 0 0 0   5a a5 3c 96
0 5 1 8 ff    0 0 0 0   5a a5 3c 96
0 1 1 8 81    0 1 0 0   5a 81 3c 96
// start bit and part of a header, zero run, then a packet
1 0 0 6 2b    0 0 0 0   5a 81 3c 96
2 0 0 28 0    0 0 0 0   5a 81 3c 96
0 2 1 8 7e    0 0 1 0   5a 81 7e 96
// random gaps
3 0 1 8 11    1 0 0 0   11 81 7e 96
3 1 1 8 22    0 1 0 0   11 22 7e 96
3 2 1 8 33    0 0 1 0   11 22 33 96
3 3 1 8 44    0 0 0 1   11 22 33 44
ff 0 0 0 0    0 0 0 0   00 00 00 00

// ==== testbench/tb_serial_tag.sv ====
`timescale 1ns/1ps

// testbench for serial_tag_top
// records come from the stim file, 13 hex words each
module tb_serial_tag
   import tag_cfg_pkg::*;
;

   localparam int NUM_CLIENTS = 4;
   localparam int DATA_W      = 8;
   localparam int REC_W       = 13;
   localparam int MAX_REC     = 40;
   localparam int WAIT_LIMIT  = 200;

   logic clk_i;
   logic arst_n_i;
   logic en_i;
   logic data_i;
   logic [NUM_CLIENTS-1:0][DATA_W-1:0] data_o;
   logic [NUM_CLIENTS-1:0]             new_o;

   logic [63:0] stim_mem [0:REC_W*MAX_REC-1];
   int          strobe_cnt [NUM_CLIENTS];
   int          errors;
   logic [31:0] lfsr_q;

   serial_tag_top UUT (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .en_i     (en_i),
      .data_i   (data_i),
      .data_o   (data_o),
      .new_o    (new_o)
   );

   // ********************
   // clock and monitor
   // ********************

   always #20 clk_i = ~clk_i;

   // outputs change on the rising edge, so read them on the falling one
   always @(negedge clk_i)
   begin
      if (arst_n_i)
      begin
         for (int k = 0; k < NUM_CLIENTS; k++)
         begin
            if (new_o[k])
            begin
               strobe_cnt[k]++;
            end
         end
      end
   end

   // ********************
   // helpers
   // ********************

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("ERR %s: got %0h expected %0h", name, got, exp);
         errors++;
      end
   endtask

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // one step per bit taken
   task automatic take_bit(output logic b);
      lfsr_q = lfsr_next(lfsr_q);
      b      = lfsr_q[0];
   endtask

   task automatic send_bit(input logic b);
      @(negedge clk_i);
      en_i   = 1'b1;
      data_i = b;
   endtask

   // en_i low, the pin value must be ignored
   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         @(negedge clk_i);
         en_i   = 1'b0;
         data_i = 1'b1;
      end
   endtask

   // start bit, header lsb first, payload lsb first
   task automatic send_packet(input logic [63:0] id, input logic [63:0] flag,
                              input logic [63:0] len, input logic [63:0] payload);
      tag_header_s hdr;
      hdr.id             = id[TAG_ID_W-1:0];
      hdr.data_not_reset = flag[0];
      hdr.len            = len[TAG_LEN_W-1:0];
      send_bit(1'b1);
      for (int i = 0; i < TAG_HDR_W; i++)
      begin
         send_bit(hdr[i]);
      end
      for (int i = 0; i < int'(len); i++)
      begin
         send_bit(payload[i]);
      end
      idle_cycles(1);
   endtask

   // ********************
   // main sequence
   // ********************

   initial
   begin
      int          base;
      int          exp_total;
      int          got_total;
      int          tries;
      int          err_before;
      int          tests;
      int          snap [NUM_CLIENTS];
      logic [63:0] kind;
      logic [63:0] len;
      logic        b;
      int          gap;

      clk_i    = 1'b0;
      arst_n_i = 1'b0;
      en_i     = 1'b0;
      data_i   = 1'b0;
      errors   = 0;
      tests    = 0;
      lfsr_q   = 32'h82ad;
      for (int k = 0; k < NUM_CLIENTS; k++)
      begin
         strobe_cnt[k] = 0;
      end
      // words past the end of the file keep an address-tagged fill
      for (int i = 0; i < REC_W * MAX_REC; i++)
      begin
         stim_mem[i] = {32'hffff_ffff, 32'(i)};
      end
      $readmemh("testbench/serial_tag_stim.txt", stim_mem);

      repeat (4) @(negedge clk_i);
      arst_n_i = 1'b1;
      idle_cycles(2);

      for (int rec = 0; rec < MAX_REC; rec++)
      begin
         base = rec * REC_W;
         kind = stim_mem[base];
         // ff ends the list, the fill pattern marks a missing end line
         if (kind == 64'hff || kind[63:32] == 32'hffff_ffff)
         begin
            break;
         end
         len        = stim_mem[base+3];
         err_before = errors;
         exp_total  = 0;
         for (int k = 0; k < NUM_CLIENTS; k++)
         begin
            snap[k]   = strobe_cnt[k];
            exp_total += int'(stim_mem[base+4+k+1]);
         end

         case (kind)
            // packet after a short idle gap
            64'h0:
            begin
               idle_cycles(2);
               send_packet(stim_mem[base+1], stim_mem[base+2], len, stim_mem[base+4]);
            end
            // raw bits, e.g. a start bit and part of a header
            64'h1:
            begin
               for (int i = 0; i < int'(len); i++)
               begin
                  send_bit(stim_mem[base+4][i]);
               end
            end
            // enabled zeros
            64'h2:
            begin
               for (int i = 0; i < int'(len); i++)
               begin
                  send_bit(1'b0);
               end
            end
            // packet after a random gap of 1 to 16 cycles
            default:
            begin
               gap = 1;
               for (int i = 0; i < 4; i++)
               begin
                  take_bit(b);
                  gap += int'(b) << i;
               end
               idle_cycles(gap);
               send_packet(stim_mem[base+1], stim_mem[base+2], len, stim_mem[base+4]);
            end
         endcase

         // wait for the expected strobes
         tries     = 0;
         got_total = 0;
         while (tries < WAIT_LIMIT)
         begin
            got_total = 0;
            for (int k = 0; k < NUM_CLIENTS; k++)
            begin
               got_total += strobe_cnt[k] - snap[k];
            end
            if (got_total >= exp_total)
            begin
               break;
            end
            @(negedge clk_i);
            tries++;
         end
         if (tries == WAIT_LIMIT)
         begin
            $display("test %0d timed out waiting for new_o strobes", rec);
            errors++;
         end
         // pin to strobe is three edges, give it room for stray strobes
         idle_cycles(4);

         for (int k = 0; k < NUM_CLIENTS; k++)
         begin
            check_value($sformatf("new_o[%0d] count", k),
                        64'(strobe_cnt[k] - snap[k]), stim_mem[base+5+k]);
            check_value($sformatf("data_o[%0d]", k),
                        64'(data_o[k]), stim_mem[base+9+k]);
         end
         tests++;
         if (errors == err_before)
         begin
            $display("test %0d kind %0h: ok", rec, kind);
         end
         else
         begin
            $display("test %0d kind %0h: mismatch", rec, kind);
         end
      end

      $display("tests %0d, errors %0d", tests, errors);
      if (errors == 0 && tests > 0)
      begin
         $display("Simulation PASSED");
      end
      else
      begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// ==== src/serial_tag_top.sv ====
`timescale 1ns/1ps

// serial configuration network
// one tag master fanned out to NUM_CLIENTS clients
module serial_tag_top
   import tag_link_pkg::*;
#(
   parameter int NUM_CLIENTS = 4,
   parameter int DATA_W      = 8
)
(
   input  logic                                clk_i,
   input  logic                                arst_n_i,
   input  logic                                en_i,
   input  logic                                data_i,
   output logic [NUM_CLIENTS-1:0][DATA_W-1:0] data_o,
   output logic [NUM_CLIENTS-1:0]             new_o
);

   // one registered link per client
   tag_link_s [NUM_CLIENTS-1:0] links;

   tag_master #(
      .NUM_CLIENTS (NUM_CLIENTS)
   ) u_master (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .en_i     (en_i),
      .data_i   (data_i),
      .links_o  (links)
   );

   // ********************
   // clients
   // ********************

   for (genvar k = 0; k < NUM_CLIENTS; k++)
   begin : g_client
      tag_client #(
         .DATA_W (DATA_W)
      ) u_client (
         .clk_i    (clk_i),
         .arst_n_i (arst_n_i),
         .link_i   (links[k]),
         .data_o   (data_o[k]),
         .new_o    (new_o[k])
      );
   end

endmodule

// ==== src/tag_client.sv ====
`timescale 1ns/1ps

// tag client
// collects data beats into a DATA_W word and publishes it with a strobe
module tag_client
   import tag_link_pkg::*;
#(
   parameter int DATA_W = 8
)
(
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  tag_link_s         link_i,
   output logic [DATA_W-1:0] data_o,
   output logic              new_o
);

   // beat counter, 0 to DATA_W-1
   localparam int CNT_W = (DATA_W > 1) ? $clog2(DATA_W) : 1;

   logic [DATA_W-1:0] shift_r;
   logic [DATA_W-1:0] shift_n;
   logic [CNT_W-1:0]  cnt_r;
   logic              data_beat;
   logic              reset_beat;

   assign data_beat  = (link_i.op == TAG_OP_DATA);
   assign reset_beat = (link_i.op == TAG_OP_RESET) && link_i.param;

   // new bit enters at the top, first bit drifts down to bit 0
   assign shift_n = {link_i.param, shift_r[DATA_W-1:1]};

   // ********************
   // shift state
   // ********************

   // partial word, only meaningful under cnt_r
   always_ff @(posedge clk_i)
   begin
      if (reset_beat)
      begin
         shift_r <= '0;
      end
      else if (data_beat)
      begin
         shift_r <= (cnt_r == CNT_W'(DATA_W - 1)) ? '0 : shift_n;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         cnt_r  <= '0;
         data_o <= '0;
         new_o  <= 1'b0;
      end
      else
      begin
         // strobe lasts one cycle
         new_o <= 1'b0;
         // reset beat drops the partial word, data_o keeps its value
         if (reset_beat)
         begin
            cnt_r <= '0;
         end
         else if (data_beat)
         begin
            if (cnt_r == CNT_W'(DATA_W - 1))
            begin
               // word complete, further bits start the next word
               cnt_r  <= '0;
               data_o <= shift_n;
               new_o  <= 1'b1;
            end
            else
            begin
               cnt_r <= cnt_r + CNT_W'(1);
            end
         end
      end
   end

   // a publish is always caused by a data beat one cycle earlier
   a_new_after_data : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $rose(new_o) |-> $past(link_i.op == TAG_OP_DATA));

endmodule

// ==== src/tag_master.sv ====
`timescale 1ns/1ps

// one-pin tag master
// samples the pin, collects the header and forwards the payload
// as op/param beats onto the link of the addressed client
module tag_master
   import tag_cfg_pkg::*;
   import tag_link_pkg::*;
#(
   parameter int NUM_CLIENTS = 4
)
(
   input  logic                        clk_i,
   input  logic                        arst_n_i,
   input  logic                        en_i,
   input  logic                        data_i,
   output tag_link_s [NUM_CLIENTS-1:0] links_o
);

   // header bit pointer, 0 to TAG_HDR_W-1
   localparam int PTR_W = $clog2(TAG_HDR_W);

   // id field can address at most 2**TAG_ID_W clients
   if (NUM_CLIENTS > (1 << TAG_ID_W))
   begin : g_bad_clients
      $error("NUM_CLIENTS exceeds the id field range");
   end

   // ********************
   // pin sampling
   // ********************

   logic bit_r;
   logic zero_reset;

   // en_i low reads as a zero bit
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         bit_r <= 1'b0;
      end
      else
      begin
         bit_r <= en_i & data_i;
      end
   end

   tag_reset_detect u_reset_detect (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .bit_i        (bit_r),
      .zero_reset_o (zero_reset)
   );

   // ********************
   // packet FSM
   // ********************

   tag_master_state_e state_r, state_n;
   logic [PTR_W-1:0]  hdr_ptr_r, hdr_ptr_n;
   tag_header_s       hdr_r, hdr_n;

   // beat to forward this cycle
   logic              beat_v;
   tag_link_s         beat;

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_r   <= IDLE;
         hdr_ptr_r <= '0;
         hdr_r     <= '0;
      end
      // zero run with no one pending aborts whatever is in flight
      else if (zero_reset && !bit_r)
      begin
         state_r   <= IDLE;
         hdr_ptr_r <= '0;
         hdr_r     <= hdr_n;
      end
      else
      begin
         state_r   <= state_n;
         hdr_ptr_r <= hdr_ptr_n;
         hdr_r     <= hdr_n;
      end
   end

   always_comb
   begin
      state_n    = state_r;
      hdr_ptr_n  = hdr_ptr_r;
      hdr_n      = hdr_r;
      beat_v     = 1'b0;
      beat.op    = TAG_OP_RESET;
      beat.param = 1'b0;

      case (state_r)
         // first one after the zeros is the start bit
         IDLE:
         begin
            hdr_ptr_n = '0;
            hdr_n     = '0;
            if (bit_r)
            begin
               state_n = HEADER;
            end
         end
         // shift in from the top, first bit ends up in bit 0
         HEADER:
         begin
            hdr_n     = tag_header_s'({bit_r, hdr_r[TAG_HDR_W-1:1]});
            hdr_ptr_n = hdr_ptr_r + PTR_W'(1);
            // last header bit, decide on the fly
            if (hdr_ptr_r == PTR_W'(TAG_HDR_W - 1))
            begin
               hdr_ptr_n = '0;
               // null packet, nothing to forward
               if (hdr_n.len == '0)
               begin
                  state_n = IDLE;
               end
               else
               begin
                  state_n = TRANSFER;
               end
            end
         end
         // one beat per payload bit, len counts down to zero
         TRANSFER:
         begin
            beat_v     = 1'b1;
            beat.op    = tag_op_e'(hdr_r.data_not_reset);
            beat.param = bit_r;
            hdr_n.len  = hdr_r.len - TAG_LEN_W'(1);
            if (hdr_r.len == TAG_LEN_W'(1))
            begin
               state_n = IDLE;
            end
         end
         default:
         begin
            state_n = IDLE;
         end
      endcase
   end

   // ********************
   // link demux
   // ********************

   // ids at or above NUM_CLIENTS match no link, payload is dropped
   logic [NUM_CLIENTS-1:0] link_busy;

   for (genvar k = 0; k < NUM_CLIENTS; k++)
   begin : g_link
      logic sel;

      assign sel = beat_v && (hdr_r.id == TAG_ID_W'(k));

      always_ff @(posedge clk_i or negedge arst_n_i)
      begin
         if (!arst_n_i)
         begin
            links_o[k] <= '0;
         end
         else
         begin
            links_o[k].op    <= sel ? beat.op : TAG_OP_RESET;
            links_o[k].param <= sel & beat.param;
         end
      end

      assign link_busy[k] = (links_o[k] != '0);
   end

   // only the addressed client ever sees a beat
   a_one_link : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      $onehot0(link_busy));

endmodule

// ==== src/tag_reset_detect.sv ====
`timescale 1ns/1ps

// counts consecutive sampled zeros on the tag pin
// the top bit of the counter is the carry out and doubles as the
// reset request, which lasts exactly one cycle
module tag_reset_detect
   import tag_cfg_pkg::*;
(
   input  logic clk_i,
   input  logic arst_n_i,
   input  logic bit_i,
   output logic zero_reset_o
);

   // ********************
   // zero counter
   // ********************

   logic [TAG_ZCNT_W-1:0] zcnt_r;

   // carry bit set after TAG_RESET_ZEROS zeros in a row
   assign zero_reset_o = zcnt_r[TAG_ZCNT_W-1];

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         zcnt_r <= '0;
      end
      // a one breaks the run, the request clears itself
      else if (bit_i || zero_reset_o)
      begin
         zcnt_r <= '0;
      end
      else
      begin
         zcnt_r <= zcnt_r + TAG_ZCNT_W'(1);
      end
   end

   // ********************
   // checks
   // ********************

   // request is a single-cycle pulse, even under a long zero run
   a_zero_reset_pulse : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      zero_reset_o |=> !zero_reset_o);

endmodule

// ==== src/tag_link_pkg.sv ====
// master to client link and master state
package tag_link_pkg;

   // link opcode
   // reset beats with param 1 clear the client shift state
   typedef enum logic {
      TAG_OP_RESET = 1'b0,
      TAG_OP_DATA  = 1'b1
   } tag_op_e;

   // one beat on a client link
   // all zero is an idle link
   typedef struct packed {
      tag_op_e op;
      logic    param;
   } tag_link_s;

   // master FSM
   //   IDLE      waiting for the start bit
   //   HEADER    shifting in the header
   //   TRANSFER  forwarding len payload bits
   typedef enum logic [1:0] {
      IDLE     = 2'd0,
      HEADER   = 2'd1,
      TRANSFER = 2'd2
   } tag_master_state_e;

endpackage

// ==== src/tag_cfg_pkg.sv ====
// packet format of the serial tag stream
//
// a run of zeros idles or resets the master, a single one starts a packet
// and the header follows, least significant bit first:
//    < len > < data_not_reset > < id >   then < payload > of len bits
// the first header bit on the wire lands in bit 0 of the header struct
package tag_cfg_pkg;

   // ********************
   // field widths
   // ********************

   // client id field, up to 16 clients
   localparam int TAG_ID_W = 4;

   // payload length field, lengths 0 to 63
   localparam int TAG_LEN_W = 6;

   // id plus flag plus length
   localparam int TAG_HDR_W = TAG_ID_W + 1 + TAG_LEN_W;

   // ********************
   // in-band reset
   // ********************

   // consecutive sampled zeros that force the master back to idle
   // power of two, so the carry bit of the counter is the request
   localparam int TAG_RESET_ZEROS = 32;

   // zero counter width, one extra bit for the carry
   localparam int TAG_ZCNT_W = $clog2(TAG_RESET_ZEROS) + 1;

   // header as it sits in the master after shift-in
   // len occupies the low bits, so it arrives first on the wire
   typedef struct packed {
      logic [TAG_ID_W-1:0]  id;
      logic                 data_not_reset;
      logic [TAG_LEN_W-1:0] len;
   } tag_header_s;

endpackage
